// ==== conv_layer.f ====
rtl/conv_pkg.sv
rtl/coef_if.sv
rtl/coef_loader.sv
rtl/window_gen.sv
rtl/channel_mac.sv
rtl/scan_ctrl.sv
rtl/conv_layer.sv
sim/conv_layer_checks.sv
sim/conv_layer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the conv_layer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module conv_layer_tb \
	-f conv_layer.f --Mdir obj_dir -o conv_layer_sim
./obj_dir/conv_layer_sim 2>&1 | tee "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	echo "simulation failed, see $LOG"
	exit 1
fi
echo "simulation passed"

// ==== sim/conv_layer_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_layer_tb;
	import conv_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int NUM_IMAGES = 2;
	localparam int RUN_CYCLES = NUM_IMAGES * IMG_H * IMG_W + NUM_WEIGHTS + NUM_CH + 50;
	localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic weight_store_done = 1'b0;
	logic bias_store_done = 1'b0;
	logic pixel_store_done = 1'b0;
	pixel_t pixel_data = '0;
	weight_t weight_data = '0;
	bias_t bias_data = '0;
	logic end_check = 1'b0;

	addr_t read_row_addr;
	addr_t read_col_addr;
	logic read_pixel_signal;
	addr_t read_weight_addr;
	logic read_weight_signal;
	addr_t read_bias_addr;
	logic read_bias_signal;
	logic save_enable;
	addr_t output_row;
	addr_t output_col;
	out_vec_t output_data;
	logic calculation_done;
	int checks;
	int errors;

	pixel_t pix_mem [IMG_H * IMG_W];
	weight_t w_mem [NUM_WEIGHTS];
	bias_t b_mem [NUM_CH];

	conv_layer uut (
		.clk                (clk),
		.rst                (rst),
		.weight_store_done  (weight_store_done),
		.bias_store_done    (bias_store_done),
		.pixel_store_done   (pixel_store_done),
		.pixel_data         (pixel_data),
		.weight_data        (weight_data),
		.bias_data          (bias_data),
		.read_row_addr      (read_row_addr),
		.read_col_addr      (read_col_addr),
		.read_pixel_signal  (read_pixel_signal),
		.read_weight_addr   (read_weight_addr),
		.read_weight_signal (read_weight_signal),
		.read_bias_addr     (read_bias_addr),
		.read_bias_signal   (read_bias_signal),
		.save_enable        (save_enable),
		.output_row         (output_row),
		.output_col         (output_col),
		.output_data        (output_data),
		.calculation_done   (calculation_done)
	);

	conv_layer_checks #(.NUM_IMAGES(NUM_IMAGES)) u_checks (
		.clk                (clk),
		.rst                (rst),
		.end_check          (end_check),
		.read_pixel_signal  (read_pixel_signal),
		.read_row_addr      (read_row_addr),
		.read_col_addr      (read_col_addr),
		.read_weight_signal (read_weight_signal),
		.read_weight_addr   (read_weight_addr),
		.read_bias_signal   (read_bias_signal),
		.read_bias_addr     (read_bias_addr),
		.save_enable        (save_enable),
		.output_row         (output_row),
		.output_col         (output_col),
		.output_data        (output_data),
		.calculation_done   (calculation_done),
		.weights_ready      (uut.coef.weights_ready),
		.biases_ready       (uut.coef.biases_ready),
		.pix_mem            (pix_mem),
		.w_mem              (w_mem),
		.b_mem              (b_mem),
		.checks             (checks),
		.errors             (errors)
	);

	initial
	begin
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// buffers answer the address of the current cycle from mid-cycle on
	always @(negedge clk)
	begin
		if (read_pixel_signal && int'(read_row_addr) < IMG_H && int'(read_col_addr) < IMG_W)
			pixel_data <= pix_mem[int'(read_row_addr) * IMG_W + int'(read_col_addr)];
		else
			pixel_data <= '0;
		if (read_weight_signal && int'(read_weight_addr) < NUM_WEIGHTS)
			weight_data <= w_mem[int'(read_weight_addr)];
		else
			weight_data <= '0;
		if (read_bias_signal && int'(read_bias_addr) < NUM_CH)
			bias_data <= b_mem[int'(read_bias_addr)];
		else
			bias_data <= '0;
	end

	task automatic fill_image();
		for (int i = 0; i < IMG_H * IMG_W; i++)
			pix_mem[i] = pixel_t'($urandom());
	endtask

	task automatic fill_coefficients();
		for (int i = 0; i < NUM_WEIGHTS; i++)
			w_mem[i] = weight_t'($urandom());
		for (int i = 0; i < NUM_CH; i++)
			b_mem[i] = bias_t'($urandom());
	endtask

	// pulse pixel_store_done and wait for the last save
	task automatic run_image();
		pixel_store_done = 1'b1;
		@(negedge clk);
		pixel_store_done = 1'b0;
		while (!calculation_done)
			@(negedge clk);
		@(negedge clk);
	endtask

	initial
	begin
		void'($urandom(32'h4f93));
		fill_coefficients();
		fill_image();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		weight_store_done = 1'b1;
		while (!read_weight_signal)
			@(negedge clk);
		while (read_weight_signal)
			@(negedge clk);
		bias_store_done = 1'b1;
		while (!read_bias_signal)
			@(negedge clk);
		while (read_bias_signal)
			@(negedge clk);
		for (int img = 0; img < NUM_IMAGES; img++)
		begin
			// later images reuse the loaded coefficients
			if (img > 0)
				fill_image();
			run_image();
		end
		end_check = 1'b1;
		repeat (2) @(negedge clk);
		#1;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/conv_layer_checks.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_layer_checks #(
	parameter int NUM_IMAGES = 2
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     end_check,
	input  wire                     read_pixel_signal,
	input  wire conv_pkg::addr_t    read_row_addr,
	input  wire conv_pkg::addr_t    read_col_addr,
	input  wire                     read_weight_signal,
	input  wire conv_pkg::addr_t    read_weight_addr,
	input  wire                     read_bias_signal,
	input  wire conv_pkg::addr_t    read_bias_addr,
	input  wire                     save_enable,
	input  wire conv_pkg::addr_t    output_row,
	input  wire conv_pkg::addr_t    output_col,
	input  wire conv_pkg::out_vec_t output_data,
	input  wire                     calculation_done,
	input  wire                     weights_ready,
	input  wire                     biases_ready,
	input  wire conv_pkg::pixel_t   pix_mem [conv_pkg::IMG_H * conv_pkg::IMG_W],
	input  wire conv_pkg::weight_t  w_mem [conv_pkg::NUM_WEIGHTS],
	input  wire conv_pkg::bias_t    b_mem [conv_pkg::NUM_CH],
	output int                      checks,
	output int                      errors
);
	import conv_pkg::*;

	int w_reads;
	int b_reads;
	int pix_reads;
	int save_idx;
	int images_done;
	int exp_row;
	int exp_col;
	int actual;
	int model;
	bit w_prev;
	bit b_prev;
	bit final_done;

	task automatic expect_true(input bit cond, input string msg);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("[ERROR] %0t: %s", $time, msg);
		end
	endtask

	// address a of the weight buffer is tap a / NUM_CH, channel a % NUM_CH
	function automatic int expected_value(input int row, input int col, input int ch);
		int sum;
		sum = int'(b_mem[ch]);
		for (int i = 0; i < K; i++)
		begin
			for (int j = 0; j < K; j++)
				sum += int'(pix_mem[(row + i) * IMG_W + col + j])
					* int'(w_mem[(i * K + j) * NUM_CH + ch]);
		end
		return sum;
	endfunction

	always @(negedge clk)
	begin
		if (rst)
			expect_true(!read_pixel_signal && !read_weight_signal && !read_bias_signal
				&& !save_enable && !calculation_done && !weights_ready && !biases_ready,
				"outputs active during reset");
		else
		begin
			// ready levels rise once the whole burst has been read
			expect_true(weights_ready == (w_reads == NUM_WEIGHTS),
				$sformatf("weights_ready is %0b after %0d weight reads",
					weights_ready, w_reads));
			expect_true(biases_ready == (b_reads == NUM_CH),
				$sformatf("biases_ready is %0b after %0d bias reads",
					biases_ready, b_reads));

			if (read_weight_signal)
			begin
				expect_true(int'(read_weight_addr) == w_reads && w_reads < NUM_WEIGHTS,
					$sformatf("weight address %0d at read %0d", read_weight_addr, w_reads));
				w_reads++;
			end
			else if (w_prev)
				expect_true(w_reads == NUM_WEIGHTS,
					$sformatf("weight burst ended after %0d reads", w_reads));
			w_prev = read_weight_signal;

			if (read_bias_signal)
			begin
				expect_true(int'(read_bias_addr) == b_reads && b_reads < NUM_CH,
					$sformatf("bias address %0d at read %0d", read_bias_addr, b_reads));
				b_reads++;
			end
			else if (b_prev)
				expect_true(b_reads == NUM_CH,
					$sformatf("bias burst ended after %0d reads", b_reads));
			b_prev = read_bias_signal;

			// raster order with the column wrapping at the image width
			if (read_pixel_signal)
			begin
				expect_true(int'(read_row_addr) == pix_reads / IMG_W
					&& int'(read_col_addr) == pix_reads % IMG_W && pix_reads < IMG_H * IMG_W,
					$sformatf("pixel address (%0d,%0d) at read %0d",
						read_row_addr, read_col_addr, pix_reads));
				pix_reads++;
			end
			else
			begin
				if (pix_reads != 0)
					expect_true(pix_reads == IMG_H * IMG_W,
						$sformatf("pixel scan ended after %0d reads", pix_reads));
				pix_reads = 0;
			end

			if (save_enable)
			begin
				exp_row = save_idx / OUT_W;
				exp_col = save_idx % OUT_W;
				expect_true(int'(output_row) == exp_row && int'(output_col) == exp_col,
					$sformatf("save at (%0d,%0d), expected (%0d,%0d)",
						output_row, output_col, exp_row, exp_col));
				for (int ch = 0; ch < NUM_CH; ch++)
				begin
					actual = int'($signed(output_data[ch]));
					model = expected_value(exp_row, exp_col, ch);
					expect_true(actual == model,
						$sformatf("(%0d,%0d) channel %0d is %0d, expected %0d",
							exp_row, exp_col, ch, actual, model));
				end
				expect_true(calculation_done == (save_idx == OUT_H * OUT_W - 1),
					$sformatf("calculation_done is %0b on save %0d", calculation_done, save_idx));
				save_idx = (save_idx == OUT_H * OUT_W - 1) ? 0 : save_idx + 1;
				if (save_idx == 0)
					images_done++;
			end
			else
				expect_true(!calculation_done, "calculation_done high without a save");

			if (end_check && !final_done)
			begin
				final_done = 1'b1;
				expect_true(w_reads == NUM_WEIGHTS && b_reads == NUM_CH,
					$sformatf("%0d weight and %0d bias reads in total", w_reads, b_reads));
				expect_true(images_done == NUM_IMAGES && save_idx == 0,
					$sformatf("%0d images and %0d extra saves", images_done, save_idx));
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/conv_layer.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_layer (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    weight_store_done,
	input  wire                    bias_store_done,
	input  wire                    pixel_store_done,
	input  wire conv_pkg::pixel_t  pixel_data,
	input  wire conv_pkg::weight_t weight_data,
	input  wire conv_pkg::bias_t   bias_data,
	output conv_pkg::addr_t        read_row_addr,
	output conv_pkg::addr_t        read_col_addr,
	output logic                   read_pixel_signal,
	output conv_pkg::addr_t        read_weight_addr,
	output logic                   read_weight_signal,
	output conv_pkg::addr_t        read_bias_addr,
	output logic                   read_bias_signal,
	output logic                   save_enable,
	output conv_pkg::addr_t        output_row,
	output conv_pkg::addr_t        output_col,
	output wire conv_pkg::out_vec_t output_data,
	output logic                   calculation_done
);
	import conv_pkg::*;

	pixel_t window [NUM_TAPS];

	coef_if coef ();

	coef_loader u_loader (
		.clk                (clk),
		.rst                (rst),
		.weight_store_done  (weight_store_done),
		.bias_store_done    (bias_store_done),
		.weight_data        (weight_data),
		.bias_data          (bias_data),
		.read_weight_addr   (read_weight_addr),
		.read_weight_signal (read_weight_signal),
		.read_bias_addr     (read_bias_addr),
		.read_bias_signal   (read_bias_signal),
		.coef               (coef.src)
	);

	window_gen u_window (
		.clk        (clk),
		.rst        (rst),
		.pixel_data (pixel_data),
		.window     (window)
	);

	scan_ctrl u_scan (
		.clk               (clk),
		.rst               (rst),
		.pixel_store_done  (pixel_store_done),
		.read_pixel_signal (read_pixel_signal),
		.read_row_addr     (read_row_addr),
		.read_col_addr     (read_col_addr),
		.save_enable       (save_enable),
		.output_row        (output_row),
		.output_col        (output_col),
		.calculation_done  (calculation_done)
	);

	// one MAC per output channel on the shared window
	for (genvar ch = 0; ch < NUM_CH; ch++)
	begin : g_ch
		weight_t ch_weights [NUM_TAPS];

		always_comb
		begin
			for (int t = 0; t < NUM_TAPS; t++)
				ch_weights[t] = coef.weights[t][ch];
		end

		channel_mac u_mac (
			.window  (window),
			.weights (ch_weights),
			.bias    (coef.biases[ch]),
			.result  (output_data[ch])
		);
	end

endmodule

`default_nettype wire

// ==== rtl/scan_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module scan_ctrl (
	input  wire             clk,
	input  wire             rst,
	input  wire             pixel_store_done,
	output logic            read_pixel_signal,
	output conv_pkg::addr_t read_row_addr,
	output conv_pkg::addr_t read_col_addr,
	output logic            save_enable,
	output conv_pkg::addr_t output_row,
	output conv_pkg::addr_t output_col,
	output logic            calculation_done
);
	import conv_pkg::*;

	scan_state_t state;
	scan_state_t state_next;
	addr_t prime_cnt;
	logic read_wrap;
	logic out_wrap;
	logic last_pos;
	logic primed;

	assign read_wrap = (read_col_addr == addr_t'(IMG_W - 1));
	assign out_wrap = (output_col == addr_t'(IMG_W - 1));
	assign last_pos = (output_row == addr_t'(OUT_H - 1)) && (output_col == addr_t'(OUT_W - 1));
	// window first complete after K-1 lines and K pixels
	assign primed = (prime_cnt == addr_t'((K - 1) * IMG_W + K - 1));

	always_comb
	begin
		state_next = state;
		case (state)
			SCAN_IDLE:
			begin
				if (pixel_store_done)
					state_next = SCAN_SETTING;
			end
			SCAN_SETTING:
			begin
				if (primed)
					state_next = SCAN_ENABLE;
			end
			SCAN_ENABLE:
			begin
				if (last_pos)
					state_next = SCAN_IDLE;
			end
			default:
				state_next = SCAN_IDLE;
		endcase
	end

	// reads stop once the last row has gone by
	assign read_pixel_signal = (state != SCAN_IDLE) && (read_row_addr < addr_t'(IMG_H));
	// last K-1 columns of each line straddle a row boundary
	assign save_enable = (state == SCAN_ENABLE) && (output_col < addr_t'(OUT_W));
	assign calculation_done = (state == SCAN_ENABLE) && last_pos;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= SCAN_IDLE;
			read_row_addr <= '0;
			read_col_addr <= '0;
			prime_cnt <= '0;
			output_row <= '0;
			output_col <= '0;
		end
		else
		begin
			state <= state_next;
			if (state == SCAN_IDLE)
			begin
				read_row_addr <= '0;
				read_col_addr <= '0;
				prime_cnt <= '0;
				output_row <= '0;
				output_col <= '0;
			end
			else
			begin
				if (read_pixel_signal)
				begin
					read_col_addr <= read_wrap ? '0 : read_col_addr + 1'b1;
					if (read_wrap)
						read_row_addr <= read_row_addr + 1'b1;
				end
				if (state == SCAN_SETTING)
					prime_cnt <= prime_cnt + 1'b1;
				if (state == SCAN_ENABLE)
				begin
					output_col <= out_wrap ? '0 : output_col + 1'b1;
					if (out_wrap)
						output_row <= output_row + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/channel_mac.sv ====
`default_nettype none
`timescale 1ns/1ps

module channel_mac (
	input  wire conv_pkg::pixel_t  window [conv_pkg::NUM_TAPS],
	input  wire conv_pkg::weight_t weights [conv_pkg::NUM_TAPS],
	input  wire conv_pkg::bias_t   bias,
	output conv_pkg::acc_t         result
);
	import conv_pkg::*;

	acc_t prod [NUM_TAPS];
	acc_t sum_l1 [NUM_TAPS/2];
	acc_t sum_l2 [2];
	acc_t sum_l3;

	always_comb
	begin
		// widen first so the product is exact
		for (int i = 0; i < NUM_TAPS; i++)
			prod[i] = acc_t'(window[i]) * acc_t'(weights[i]);
		for (int i = 0; i < NUM_TAPS / 2; i++)
			sum_l1[i] = prod[2*i] + prod[2*i + 1];
		sum_l2[0] = sum_l1[0] + sum_l1[1];
		sum_l2[1] = sum_l1[2] + sum_l1[3];
		sum_l3 = sum_l2[0] + sum_l2[1];
		// odd tap and bias join at the last level
		result = sum_l3 + prod[NUM_TAPS-1] + acc_t'(bias);
	end

endmodule

`default_nettype wire

// ==== rtl/window_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module window_gen (
	input  wire                   clk,
	input  wire                   rst,
	input  wire conv_pkg::pixel_t pixel_data,
	output conv_pkg::pixel_t      window [conv_pkg::NUM_TAPS]
);
	import conv_pkg::*;

	// cols[row][col], row 0 on top, col 0 holds the oldest pixel
	pixel_t cols [K][K];
	pixel_t dly [K-1][IMG_W-K];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int r = 0; r < K; r++)
			begin
				for (int c = 0; c < K; c++)
					cols[r][c] <= '0;
			end
			for (int r = 0; r < K - 1; r++)
			begin
				for (int s = 0; s < IMG_W - K; s++)
					dly[r][s] <= '0;
			end
		end
		else
		begin
			// newest pixel enters bottom right
			cols[K-1][K-1] <= pixel_data;
			for (int r = 0; r < K; r++)
			begin
				for (int c = 0; c < K - 1; c++)
					cols[r][c] <= cols[r][c+1];
			end
			// row below feeds the row above after the rest of a line
			for (int r = 0; r < K - 1; r++)
			begin
				dly[r][IMG_W-K-1] <= cols[r+1][0];
				for (int s = 0; s < IMG_W - K - 1; s++)
					dly[r][s] <= dly[r][s+1];
				cols[r][K-1] <= dly[r][0];
			end
		end
	end

	always_comb
	begin
		for (int r = 0; r < K; r++)
		begin
			for (int c = 0; c < K; c++)
				window[r*K + c] = cols[r][c];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/coef_loader.sv ====
`default_nettype none
`timescale 1ns/1ps

module coef_loader (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    weight_store_done,
	input  wire                    bias_store_done,
	input  wire conv_pkg::weight_t weight_data,
	input  wire conv_pkg::bias_t   bias_data,
	output conv_pkg::addr_t        read_weight_addr,
	output logic                   read_weight_signal,
	output conv_pkg::addr_t        read_bias_addr,
	output logic                   read_bias_signal,
	coef_if.src                    coef
);
	import conv_pkg::*;

	coef_state_t w_state;
	coef_state_t w_next;
	coef_state_t b_state;
	coef_state_t b_next;
	addr_t w_load_cnt;
	addr_t b_load_cnt;
	weight_t w_chain [NUM_WEIGHTS];
	bias_t b_chain [NUM_CH];

	// both loaders stay in set until reset
	always_comb
	begin
		w_next = w_state;
		b_next = b_state;
		if (w_state == COEF_IDLE && weight_store_done)
			w_next = COEF_SET;
		if (b_state == COEF_IDLE && bias_store_done)
			b_next = COEF_SET;
	end

	assign read_weight_signal = (w_state == COEF_SET) && (w_load_cnt != addr_t'(NUM_WEIGHTS));
	assign read_bias_signal = (b_state == COEF_SET) && (b_load_cnt != addr_t'(NUM_CH));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_state <= COEF_IDLE;
			b_state <= COEF_IDLE;
			read_weight_addr <= '0;
			read_bias_addr <= '0;
			w_load_cnt <= '0;
			b_load_cnt <= '0;
		end
		else
		begin
			w_state <= w_next;
			b_state <= b_next;
			// load count freezes at its total, the address falls back to zero
			if (read_weight_signal)
			begin
				read_weight_addr <= read_weight_addr + 1'b1;
				w_load_cnt <= w_load_cnt + 1'b1;
			end
			else
				read_weight_addr <= '0;
			if (read_bias_signal)
			begin
				read_bias_addr <= read_bias_addr + 1'b1;
				b_load_cnt <= b_load_cnt + 1'b1;
			end
			else
				read_bias_addr <= '0;
		end
	end

	// words enter at the top end, so address a settles at index a
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_WEIGHTS; i++)
				w_chain[i] <= '0;
			for (int i = 0; i < NUM_CH; i++)
				b_chain[i] <= '0;
		end
		else
		begin
			if (read_weight_signal)
			begin
				w_chain[NUM_WEIGHTS-1] <= weight_data;
				for (int i = 0; i < NUM_WEIGHTS - 1; i++)
					w_chain[i] <= w_chain[i+1];
			end
			if (read_bias_signal)
			begin
				b_chain[NUM_CH-1] <= bias_data;
				for (int i = 0; i < NUM_CH - 1; i++)
					b_chain[i] <= b_chain[i+1];
			end
		end
	end

	// flat index is tap * NUM_CH + channel
	always_comb
	begin
		for (int t = 0; t < NUM_TAPS; t++)
		begin
			for (int c = 0; c < NUM_CH; c++)
				coef.weights[t][c] = w_chain[t*NUM_CH + c];
		end
		coef.biases = b_chain;
		coef.weights_ready = (w_state == COEF_SET) && (w_load_cnt == addr_t'(NUM_WEIGHTS));
		coef.biases_ready = (b_state == COEF_SET) && (b_load_cnt == addr_t'(NUM_CH));
	end

endmodule

`default_nettype wire

// ==== rtl/coef_if.sv ====
`default_nettype none
`timescale 1ns/1ps

interface coef_if;
	import conv_pkg::*;

	// weights indexed [tap][channel]
	weight_t weights [NUM_TAPS][NUM_CH];
	bias_t biases [NUM_CH];
	logic weights_ready;
	logic biases_ready;

	modport src (
		output weights,
		output biases,
		output weights_ready,
		output biases_ready
	);

	modport dst (
		input weights,
		input biases,
		input weights_ready,
		input biases_ready
	);

endinterface

`default_nettype wire

// ==== rtl/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

	// image and layer sizes
	localparam int IMG_W = 8;
	localparam int IMG_H = 8;
	localparam int NUM_CH = 4;
	localparam int NUM_TAPS = 9;
	localparam int K = 3;
	localparam int OUT_W = IMG_W - 2;
	localparam int OUT_H = IMG_H - 2;
	localparam int NUM_WEIGHTS = NUM_TAPS * NUM_CH;

	typedef logic [15:0] addr_t;
	typedef logic signed [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;

	// nine 8x8 products plus a 16-bit bias never leave 20 bits
	typedef logic signed [19:0] acc_t;

	// channel 0 sits in the low bits
	typedef acc_t [NUM_CH-1:0] out_vec_t;

	typedef enum logic {
		COEF_IDLE,
		COEF_SET
	} coef_state_t;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_SETTING,
		SCAN_ENABLE
	} scan_state_t;

endpackage

`default_nettype wire
